/* source/spad_pkg.sv */
package spad_pkg;

   // number of bits held in one scratchpad word
   localparam int SPAD_WIDTH = 32;

   // number of words in the scratchpad
   localparam int SPAD_ELS = 16;

   // address width follows from the depth
   // with 16 words this comes out to 4 bits
   localparam int SPAD_ADDR_W = $clog2(SPAD_ELS);

   // command opcodes accepted on the command port
   // every command except a read writes through the bit mask
   typedef enum logic [1:0]
   {
      // read the word at the address
      SPAD_OP_READ  = 2'b00,
      // masked write of the command data
      SPAD_OP_WRITE = 2'b01,
      // masked lanes become one
      SPAD_OP_SET   = 2'b10,
      // masked lanes become zero
      SPAD_OP_CLEAR = 2'b11
   } spad_op_e;

   // lane data patterns used by set and clear
   localparam logic [SPAD_WIDTH-1:0] SPAD_ALL_ONES  = '1;
   localparam logic [SPAD_WIDTH-1:0] SPAD_ALL_ZEROS = '0;

endpackage

/* source/spad_mem_1rw_mask.sv */
`timescale 1ns/1ps

// single port synchronous memory with a write mask per bit
// only one read or one write happens in a cycle
module spad_mem_1rw_mask
   import spad_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   v_i,
   input  logic                   w_i,
   input  logic [SPAD_ADDR_W-1:0] addr_i,
   input  logic [SPAD_WIDTH-1:0]  data_i,
   input  logic [SPAD_WIDTH-1:0]  w_mask_i,
   output logic [SPAD_WIDTH-1:0]  data_o
);

   // the storage array itself
   // contents are undefined until a location is written
   logic [SPAD_WIDTH-1:0] mem [SPAD_ELS];

   // address captured on a read
   logic [SPAD_ADDR_W-1:0] addr_r;

   // a read is a valid command that is not a write
   logic read_en;

   // a write is a valid command with the write strobe up
   logic write_en;

   // the word at the addressed location before the write
   logic [SPAD_WIDTH-1:0] old_word;

   // the merged word that goes back into the array
   logic [SPAD_WIDTH-1:0] data_n;

   assign read_en  = v_i & ~w_i;
   assign write_en = v_i & w_i;

   // register the read address so the data shows up one cycle later
   // the address holds between reads so the output stays on the last read word
   always_ff @(posedge clk_i)
   begin
      if (read_en)
      begin
         addr_r <= addr_i;
      end
   end

   // read data is combinational from the registered address
   assign data_o = mem[addr_r];

   // old contents of the location being written
   assign old_word = mem[addr_i];

   // merge the new bits into the old word lane by lane
   // a set mask bit takes the new data and a clear one keeps the stored bit
   always_comb
   begin
      for (int i = 0; i < SPAD_WIDTH; i++)
      begin
         data_n[i] = w_mask_i[i] ? data_i[i] : old_word[i];
      end
   end

   // the whole merged word is stored in one assignment
   // this avoids a nonblocking assignment per bit inside a loop
   always_ff @(posedge clk_i)
   begin
      if (write_en)
      begin
         mem[addr_i] <= data_n;
      end
   end

endmodule

/* source/spad_read_hold.sv */
`timescale 1ns/1ps

// holds the result of the most recent read
// the output only changes on a cycle where fresh read data arrives
module spad_read_hold
   import spad_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  load_i,
   input  logic [SPAD_WIDTH-1:0] data_i,
   output logic [SPAD_WIDTH-1:0] data_o
);

   // captured copy of the last read word
   logic [SPAD_WIDTH-1:0] data_r;

   // capture the word on the cycle the read completes
   // reset clears it so the output reads zero before the first read
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         data_r <= '0;
      end
      else if (load_i)
      begin
         data_r <= data_i;
      end
   end

   // fresh data bypasses the register on the completing cycle
   // on all other cycles the captured word is driven
   always_comb
   begin
      if (load_i)
      begin
         data_o = data_i;
      end
      else
      begin
         data_o = data_r;
      end
   end

endmodule

/* source/spad_cmd_decode.sv */
`timescale 1ns/1ps

// turns one command per cycle into memory strobes
// also tracks when a read completes on the following cycle
module spad_cmd_decode
   import spad_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic                   cmd_v_i,
   input  spad_op_e               cmd_op_i,
   input  logic [SPAD_ADDR_W-1:0] cmd_addr_i,
   input  logic [SPAD_WIDTH-1:0]  cmd_data_i,
   input  logic [SPAD_WIDTH-1:0]  cmd_mask_i,
   output logic                   mem_v_o,
   output logic                   mem_w_o,
   output logic [SPAD_ADDR_W-1:0] mem_addr_o,
   output logic [SPAD_WIDTH-1:0]  mem_data_o,
   output logic [SPAD_WIDTH-1:0]  mem_mask_o,
   output logic                   rd_valid_o
);

   // write class opcode flag from the decode below
   logic op_write;

   // lane data chosen by the opcode
   logic [SPAD_WIDTH-1:0] lane_data;

   // a read issued in this cycle
   logic rd_issue;

   // registered copy of rd_issue
   logic rd_valid_r;

   // decode the opcode into a write flag and the lane data
   // set and clear reuse the masked write path with a fixed pattern
   always_comb
   begin
      op_write  = 1'b0;
      lane_data = SPAD_ALL_ZEROS;
      unique case (cmd_op_i)
         SPAD_OP_READ:
         begin
            op_write  = 1'b0;
            lane_data = SPAD_ALL_ZEROS;
         end
         SPAD_OP_WRITE:
         begin
            op_write  = 1'b1;
            lane_data = cmd_data_i;
         end
         SPAD_OP_SET:
         begin
            op_write  = 1'b1;
            lane_data = SPAD_ALL_ONES;
         end
         SPAD_OP_CLEAR:
         begin
            op_write  = 1'b1;
            lane_data = SPAD_ALL_ZEROS;
         end
      endcase
   end

   // every command strobe is accepted and goes straight to the memory
   assign mem_v_o    = cmd_v_i;
   assign mem_w_o    = cmd_v_i & op_write;
   assign mem_addr_o = cmd_addr_i;
   assign mem_data_o = lane_data;

   // the mask only matters on writes
   // a read sends an empty mask so no lane could ever be touched
   assign mem_mask_o = op_write ? cmd_mask_i : SPAD_ALL_ZEROS;

   // a valid command that does not write is a read
   assign rd_issue = cmd_v_i & ~op_write;

   // the memory returns data one cycle after the read command
   // so the read completion is the issue flag delayed by one cycle
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         rd_valid_r <= 1'b0;
      end
      else
      begin
         rd_valid_r <= rd_issue;
      end
   end

   assign rd_valid_o = rd_valid_r;

endmodule

/* source/spad_top.sv */
`timescale 1ns/1ps

// bit masked scratchpad
// one command per cycle with read data returned on the next cycle
module spad_top
   import spad_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic                   cmd_v_i,
   input  spad_op_e               cmd_op_i,
   input  logic [SPAD_ADDR_W-1:0] cmd_addr_i,
   input  logic [SPAD_WIDTH-1:0]  cmd_data_i,
   input  logic [SPAD_WIDTH-1:0]  cmd_mask_i,
   output logic                   rd_valid_o,
   output logic [SPAD_WIDTH-1:0]  rd_data_o
);

   // decoder to memory strobes and payload
   logic                   mem_v;
   logic                   mem_w;
   logic [SPAD_ADDR_W-1:0] mem_addr;
   logic [SPAD_WIDTH-1:0]  mem_data;
   logic [SPAD_WIDTH-1:0]  mem_mask;

   // word at the registered read address
   logic [SPAD_WIDTH-1:0]  mem_rdata;

   // read completion from the decoder
   // it loads the hold register and is also the top level valid
   logic                   rd_valid;

   spad_cmd_decode u_decode (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .cmd_v_i    (cmd_v_i),
      .cmd_op_i   (cmd_op_i),
      .cmd_addr_i (cmd_addr_i),
      .cmd_data_i (cmd_data_i),
      .cmd_mask_i (cmd_mask_i),
      .mem_v_o    (mem_v),
      .mem_w_o    (mem_w),
      .mem_addr_o (mem_addr),
      .mem_data_o (mem_data),
      .mem_mask_o (mem_mask),
      .rd_valid_o (rd_valid)
   );

   spad_mem_1rw_mask u_mem (
      .clk_i    (clk_i),
      .v_i      (mem_v),
      .w_i      (mem_w),
      .addr_i   (mem_addr),
      .data_i   (mem_data),
      .w_mask_i (mem_mask),
      .data_o   (mem_rdata)
   );

   spad_read_hold u_hold (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .load_i (rd_valid),
      .data_i (mem_rdata),
      .data_o (rd_data_o)
   );

   assign rd_valid_o = rd_valid;

endmodule

/* dv/spad_tb_clk.sv */
`timescale 1ns/1ps

// free running clock for the scratchpad testbench
// 20 ns period with the first rising edge at 10 ns
module spad_tb_clk
(
   output logic clk_o
);

   // half of the clock period in ns
   localparam int HALF_PERIOD_NS = 10;

   initial
   begin
      clk_o = 1'b0;
      forever
      begin
         #(HALF_PERIOD_NS) clk_o = ~clk_o;
      end
   end

endmodule

/* dv/spad_assert.sv */
`timescale 1ns/1ps

// protocol checks on the scratchpad top level ports
// bound into spad_top so it sees the same signals as the testbench
module spad_assert
   import spad_pkg::*;
(
   input logic                  clk_i,
   input logic                  rst_i,
   input logic                  cmd_v_i,
   input spad_op_e              cmd_op_i,
   input logic                  rd_valid_i,
   input logic [SPAD_WIDTH-1:0] rd_data_i
);

   // a read command accepted in this cycle
   logic read_cmd;

   assign read_cmd = cmd_v_i && (cmd_op_i == SPAD_OP_READ);

   // the valid flag is cleared by reset and stays low while it is held
   a_valid_low_in_reset : assert property (@(posedge clk_i) rst_i |=> !rd_valid_i)
      else $error("rd_valid_o was high while reset was held");

   // every read outside reset completes exactly one cycle later
   a_valid_after_read : assert property (@(posedge clk_i) (!rst_i && read_cmd) |=> rd_valid_i)
      else $error("rd_valid_o did not follow a read command by one cycle");

   // no completion appears unless a read was issued the cycle before
   a_no_valid_without_read : assert property (@(posedge clk_i) !read_cmd |=> !rd_valid_i)
      else $error("rd_valid_o rose without a read command one cycle earlier");

   // the read result is held on every cycle that does not complete a read
   a_data_held : assert property (@(posedge clk_i)
      (!rst_i && !$past(rst_i) && !rd_valid_i) |-> $stable(rd_data_i))
      else $error("rd_data_o changed on a cycle without rd_valid_o");

endmodule

bind spad_top spad_assert spad_assert_inst (
   .clk_i      (clk_i),
   .rst_i      (rst_i),
   .cmd_v_i    (cmd_v_i),
   .cmd_op_i   (cmd_op_i),
   .rd_valid_i (rd_valid_o),
   .rd_data_i  (rd_data_o)
);

/* include/spad_defs.svh */
`ifndef SPAD_DEFS_SVH
`define SPAD_DEFS_SVH

// stimulus is applied this many ns after each rising clock edge
// so that inputs are stable well before the next sampling edge
`define SPAD_STIM_DLY 2

// the clock period of the testbench clock in ns
`define SPAD_CLK_PERIOD 20

`endif

/* dv/spad_tb.sv */
`timescale 1ns/1ps

`include "spad_defs.svh"

// table driven testbench for the bit masked scratchpad
// a reference model tracks the expected memory contents and read output
module spad_tb
   import spad_pkg::*;
();

   // number of commands in the stimulus table
   localparam int TBL_LEN = 40;

   // reset is held for this many clock cycles
   localparam int RST_CYCLES = 8;

   // four clock periods per command plus the reset time
   localparam int WATCHDOG_NS = TBL_LEN * `SPAD_CLK_PERIOD * 4
                              + RST_CYCLES * `SPAD_CLK_PERIOD;

   logic                   clk;
   logic                   rst;
   logic                   cmd_v;
   spad_op_e               cmd_op;
   logic [SPAD_ADDR_W-1:0] cmd_addr;
   logic [SPAD_WIDTH-1:0]  cmd_data;
   logic [SPAD_WIDTH-1:0]  cmd_mask;
   logic                   rd_valid;
   logic [SPAD_WIDTH-1:0]  rd_data;

   // the stimulus table, one command per entry and per cycle
   logic                   tbl_v    [TBL_LEN];
   spad_op_e               tbl_op   [TBL_LEN];
   logic [SPAD_ADDR_W-1:0] tbl_addr [TBL_LEN];
   logic [SPAD_WIDTH-1:0]  tbl_data [TBL_LEN];
   logic [SPAD_WIDTH-1:0]  tbl_mask [TBL_LEN];
   int                     tbl_fill;

   // reference model of the storage, plus which words hold known data
   logic [SPAD_WIDTH-1:0]  model_mem     [SPAD_ELS];
   logic                   model_written [SPAD_ELS];

   // expected outputs for the current cycle
   logic                   exp_valid;
   logic [SPAD_WIDTH-1:0]  exp_data;

   spad_tb_clk clk_gen_inst (
      .clk_o (clk)
   );

   spad_top spad_top_inst (
      .clk_i      (clk),
      .rst_i      (rst),
      .cmd_v_i    (cmd_v),
      .cmd_op_i   (cmd_op),
      .cmd_addr_i (cmd_addr),
      .cmd_data_i (cmd_data),
      .cmd_mask_i (cmd_mask),
      .rd_valid_o (rd_valid),
      .rd_data_o  (rd_data)
   );

   // ends the run on the first failure
   task automatic fail_run(input string msg);
      $display("Errors found");
      $fatal(1, "%s", msg);
   endtask

   task automatic check_word(input logic [SPAD_WIDTH-1:0] got,
                             input logic [SPAD_WIDTH-1:0] exp,
                             input string what);
      if (got !== exp)
      begin
         $display("MISMATCH at time %0t: %s is %h, expected %h", $time, what, got, exp);
         fail_run("a data word differs from the reference model");
      end
   endtask

   task automatic check_valid(input logic got, input logic exp, input string what);
      if (got !== exp)
      begin
         $display("MISMATCH at time %0t: %s is %b, expected %b", $time, what, got, exp);
         fail_run("the read valid flag differs from the reference model");
      end
   endtask

   function automatic logic [SPAD_WIDTH-1:0] random_word();
      return SPAD_WIDTH'($urandom());
   endfunction

   task automatic add_cmd(input logic v, input spad_op_e op, input int addr,
                          input logic [SPAD_WIDTH-1:0] data,
                          input logic [SPAD_WIDTH-1:0] mask);
      if (tbl_fill >= TBL_LEN)
      begin
         fail_run("the stimulus table overflowed its declared length");
      end
      tbl_v[tbl_fill]    = v;
      tbl_op[tbl_fill]   = op;
      tbl_addr[tbl_fill] = SPAD_ADDR_W'(addr);
      tbl_data[tbl_fill] = data;
      tbl_mask[tbl_fill] = mask;
      tbl_fill++;
   endtask

   // the data and mask of most entries are random and filled once at start
   task automatic build_table();
      logic [SPAD_WIDTH-1:0] full;
      full = '1;
      // full mask writes to the first four words and then back to back reads of them
      for (int a = 0; a < 4; a++)
      begin
         add_cmd(1'b1, SPAD_OP_WRITE, a, random_word(), full);
      end
      for (int a = 0; a < 4; a++)
      begin
         add_cmd(1'b1, SPAD_OP_READ, a, '0, '0);
      end
      // an empty mask leaves the word alone
      add_cmd(1'b1, SPAD_OP_WRITE, 0, random_word(), '0);
      add_cmd(1'b1, SPAD_OP_READ, 0, '0, '0);
      // partial write, set and clear each followed by a read of the same word
      add_cmd(1'b1, SPAD_OP_WRITE, 1, random_word(), random_word());
      add_cmd(1'b1, SPAD_OP_READ, 1, '0, '0);
      add_cmd(1'b1, SPAD_OP_SET, 2, random_word(), random_word());
      add_cmd(1'b1, SPAD_OP_READ, 2, '0, '0);
      add_cmd(1'b1, SPAD_OP_CLEAR, 3, random_word(), random_word());
      add_cmd(1'b1, SPAD_OP_READ, 3, '0, '0);
      // writes with idle cycles in between while the last read result must hold
      add_cmd(1'b1, SPAD_OP_WRITE, 5, random_word(), full);
      add_cmd(1'b0, SPAD_OP_READ, 0, '0, '0);
      add_cmd(1'b0, SPAD_OP_READ, 0, '0, '0);
      add_cmd(1'b1, SPAD_OP_WRITE, 6, random_word(), full);
      add_cmd(1'b1, SPAD_OP_READ, 5, '0, '0);
      add_cmd(1'b1, SPAD_OP_READ, 6, '0, '0);
      // fixed lane patterns for set and clear
      add_cmd(1'b1, SPAD_OP_SET, 5, random_word(), 32'h0000_ffff);
      add_cmd(1'b1, SPAD_OP_CLEAR, 6, random_word(), 32'hff00_ff00);
      add_cmd(1'b1, SPAD_OP_READ, 5, '0, '0);
      add_cmd(1'b1, SPAD_OP_READ, 6, '0, '0);
      // random write class ops over a second group of words
      for (int a = 8; a < 12; a++)
      begin
         add_cmd(1'b1, SPAD_OP_WRITE, a, random_word(), full);
      end
      for (int a = 8; a < 12; a++)
      begin
         add_cmd(1'b1, spad_op_e'(2'($urandom_range(3, 1))), a, random_word(), random_word());
      end
      for (int a = 8; a < 12; a++)
      begin
         add_cmd(1'b1, SPAD_OP_READ, a, '0, '0);
      end
      add_cmd(1'b0, SPAD_OP_READ, 0, '0, '0);
      add_cmd(1'b1, SPAD_OP_READ, 1, '0, '0);
      if (tbl_fill != TBL_LEN)
      begin
         fail_run("the stimulus table does not match its declared length");
      end
   endtask

   task automatic drive_cmd(input int idx);
      cmd_v    = tbl_v[idx];
      cmd_op   = tbl_op[idx];
      cmd_addr = tbl_addr[idx];
      cmd_data = tbl_data[idx];
      cmd_mask = tbl_mask[idx];
   endtask

   // applies one table entry to the model after the DUT has sampled it
   task automatic model_step(input int idx);
      logic [SPAD_ADDR_W-1:0] a;
      logic [SPAD_WIDTH-1:0]  old;
      logic [SPAD_WIDTH-1:0]  mask;
      a         = tbl_addr[idx];
      old       = model_mem[a];
      mask      = tbl_mask[idx];
      exp_valid = 1'b0;
      if (tbl_v[idx])
      begin
         if (tbl_op[idx] == SPAD_OP_READ)
         begin
            if (!model_written[a])
            begin
               fail_run("the stimulus table reads a word that was never fully written");
            end
            // read data is the word as it stood when the read was taken
            exp_valid = 1'b1;
            exp_data  = old;
         end
         else
         begin
            case (tbl_op[idx])
               SPAD_OP_WRITE: model_mem[a] = (old & ~mask) | (tbl_data[idx] & mask);
               SPAD_OP_SET:   model_mem[a] = old | mask;
               SPAD_OP_CLEAR: model_mem[a] = old & ~mask;
               default:       model_mem[a] = old;
            endcase
            // a word is fully known once every bit has been written
            model_written[a] = model_written[a] | (mask == '1);
         end
      end
   endtask

   // watchdog so a stuck run cannot hang the simulator
   initial
   begin
      #(WATCHDOG_NS);
      fail_run("watchdog expired before the stimulus table finished");
   end

   initial
   begin
      tbl_fill    = 0;
      rst         = 1'b1;
      cmd_v       = 1'b0;
      cmd_op      = SPAD_OP_READ;
      cmd_addr    = '0;
      cmd_data    = '0;
      cmd_mask    = '0;
      exp_valid   = 1'b0;
      exp_data    = '0;
      for (int a = 0; a < SPAD_ELS; a++)
      begin
         model_mem[a]     = '0;
         model_written[a] = 1'b0;
      end
      void'($urandom(89));
      build_table();

      repeat (RST_CYCLES) @(posedge clk);
      #(`SPAD_STIM_DLY);
      rst = 1'b0;
      check_valid(rd_valid, 1'b0, "rd_valid_o after reset");
      check_word(rd_data, '0, "rd_data_o after reset");

      // each entry is driven after an edge, sampled at the next edge,
      // and the outputs are checked a stimulus delay after that edge
      for (int i = 0; i < TBL_LEN; i++)
      begin
         drive_cmd(i);
         @(posedge clk);
         #(`SPAD_STIM_DLY);
         model_step(i);
         check_valid(rd_valid, exp_valid, $sformatf("rd_valid_o after entry %0d", i));
         check_word(rd_data, exp_data, $sformatf("rd_data_o after entry %0d", i));
      end

      // two idle cycles at the end where the last read result must stay put
      cmd_v     = 1'b0;
      exp_valid = 1'b0;
      repeat (2)
      begin
         @(posedge clk);
         #(`SPAD_STIM_DLY);
         check_valid(rd_valid, exp_valid, "rd_valid_o in trailing idle cycle");
         check_word(rd_data, exp_data, "rd_data_o in trailing idle cycle");
      end

      $display("No errors");
      $finish;
   end

endmodule

/* vlog.f */
+incdir+include
source/spad_pkg.sv
source/spad_mem_1rw_mask.sv
source/spad_read_hold.sv
source/spad_cmd_decode.sv
source/spad_top.sv
dv/spad_tb_clk.sv
dv/spad_assert.sv
dv/spad_tb.sv

/* run.sh */
#!/bin/sh
# build the scratchpad testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=spad_sim

if ! command -v verilator >/dev/null 2>&1; then
   echo "verilator was not found on the PATH"
   exit 1
fi

verilator --binary --timing --assert \
   -f vlog.f \
   --top-module spad_tb \
   -Mdir "$BUILD_DIR" \
   -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit $status
fi

"./$BUILD_DIR/$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
   exit $status
fi

exit 0
